/* vlog.f */
design/scpad_types_pkg.sv
design/dram_bus_pkg.sv
design/scpad_sram_bank.sv
design/scpad_store_engine.sv
design/dram_write_req_queue.sv
design/scpad_backend_top.sv
verification/scpad_backend_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the scratchpad backend testbench with verilator
# the result comes from the pass line in sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f vlog.f --top-module scpad_backend_tb \
    -o scpad_backend_sim \
    && ./obj_dir/scpad_backend_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation run failed"; exit 1; }
cat sim.log
grep -qx "NO ERRORS" sim.log && exit 0 || exit 1

/* verification/scpad_backend_tb.sv */
`timescale 1ns/1ps

module scpad_backend_tb;
    import scpad_types_pkg::*;
    import dram_bus_pkg::*;

    localparam int QUEUE_DEPTH = 8;

    // cycle budgets per test
    localparam int RESET_TEST_CYCLES  = 20;
    localparam int SINGLE_TEST_CYCLES = 160;
    localparam int B2B_TEST_CYCLES    = 80;
    localparam int BP_TEST_CYCLES     = 40;
    localparam int SAME_TEST_CYCLES   = 30;
    localparam int MIX_TEST_CYCLES    = 430;
    localparam int CYCLE_LIMIT = 2 * (RESET_TEST_CYCLES + SINGLE_TEST_CYCLES + B2B_TEST_CYCLES
        + BP_TEST_CYCLES + SAME_TEST_CYCLES + MIX_TEST_CYCLES) + 200;

    // random mix length in cycles
    localparam int MIX_CYCLES = 400;

    // one expected dram write request
    typedef struct packed {
        logic [DRAM_ADDR_WIDTH-1:0] addr;
        logic [DRAM_ID_WIDTH-1:0]   id;
        num_bytes_t                 num_bytes;
        scpad_data_t                data;
    } exp_req_t;

    logic                        clk;
    logic                        n_rst;
    logic                        host_we;
    logic [SCPAD_ADDR_WIDTH-1:0] host_addr;
    scpad_data_t                 host_wdata;
    logic                        sched_write;
    logic [SCPAD_ADDR_WIDTH-1:0] sched_sram_addr;
    logic [DRAM_ADDR_WIDTH-1:0]  sched_dram_addr;
    logic [DRAM_ID_WIDTH-1:0]    sched_id;
    num_bytes_t                  sched_num_bytes;
    logic                        sched_busy;
    logic                        dram_wr_valid;
    logic [DRAM_ADDR_WIDTH-1:0]  dram_wr_addr;
    logic [DRAM_ID_WIDTH-1:0]    dram_wr_id;
    num_bytes_t                  dram_wr_num_bytes;
    scpad_data_t                 dram_wr_data;
    logic                        dram_req_accepted;

    int seed = 98576;
    int errors;
    int checks;
    int errors_before_test;
    int cycle_count;
    // acceptance chance in percent for the dram model
    int accept_pct;

    // dut outputs seen at the falling edge
    logic        sampled_valid;
    // data of the last request taken by the dram model
    scpad_data_t last_data;

    // reference model
    scpad_data_t model_rows [SCPAD_ROWS];
    exp_req_t    exp_q [$];

    scpad_backend_top #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) dut0 (
        .clk               (clk),
        .n_rst             (n_rst),
        .host_we           (host_we),
        .host_addr         (host_addr),
        .host_wdata        (host_wdata),
        .sched_write       (sched_write),
        .sched_sram_addr   (sched_sram_addr),
        .sched_dram_addr   (sched_dram_addr),
        .sched_id          (sched_id),
        .sched_num_bytes   (sched_num_bytes),
        .sched_busy        (sched_busy),
        .dram_wr_valid     (dram_wr_valid),
        .dram_wr_addr      (dram_wr_addr),
        .dram_wr_id        (dram_wr_id),
        .dram_wr_num_bytes (dram_wr_num_bytes),
        .dram_wr_data      (dram_wr_data),
        .dram_req_accepted (dram_req_accepted)
    );

    // 40 ns clock
    always #20 clk = ~clk;

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed);
        return int'((r & 32'h7fff_ffff) % n);
    endfunction

    function automatic scpad_data_t rand_row();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = $random(seed);
        lo = $random(seed);
        return {hi, lo};
    endfunction

    // keep only the low bytes given by the count
    // count 0 keeps the whole row
    function automatic scpad_data_t masked_row(input scpad_data_t row, input num_bytes_t nb);
        int          keep;
        scpad_data_t mask;
        keep = (nb == '0) ? ROW_BYTES : int'(nb);
        mask = '1;
        mask = mask >> (BYTE_WIDTH * (ROW_BYTES - keep));
        return row & mask;
    endfunction

    task automatic check_flag(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            $display("CHECK FAILED at %0t: %s", $time, what);
            errors++;
        end
    endtask

    task automatic compare_field(input logic [63:0] got, input logic [63:0] exp,
                                 input string name);
        checks++;
        assert (got == exp) else begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // dram model takes the head request
    task automatic check_popped_request();
        exp_req_t exp;
        checks++;
        assert (exp_q.size() != 0) else begin
            $display("DUT handed over a write request that no store produced, at %0t", $time);
            errors++;
        end
        if (exp_q.size() != 0) begin
            exp = exp_q.pop_front();
            compare_field(64'(dram_wr_addr), 64'(exp.addr), "dram_wr_addr");
            compare_field(64'(dram_wr_id), 64'(exp.id), "dram_wr_id");
            compare_field(64'(dram_wr_num_bytes), 64'(exp.num_bytes), "dram_wr_num_bytes");
            compare_field(64'(dram_wr_data), 64'(exp.data), "dram_wr_data");
        end
        last_data = dram_wr_data;
    endtask

    // sample and pop at the falling edge
    // then drive new inputs 2 ns after the rising edge
    task automatic tick();
        @(negedge clk);
        sampled_valid = dram_wr_valid;
        if (dram_wr_valid && dram_req_accepted) begin
            check_popped_request();
        end
        @(posedge clk);
        #2;
        host_we     = 1'b0;
        sched_write = 1'b0;
        // acceptance only for a presented request
        dram_req_accepted = dram_wr_valid && (rand_below(100) < accept_pct);
    endtask

    task automatic host_write(input logic [SCPAD_ADDR_WIDTH-1:0] row, input scpad_data_t data);
        host_we    = 1'b1;
        host_addr  = row;
        host_wdata = data;
        model_rows[row] = data;
    endtask

    // expected request uses the row as it stands now
    // a host write in the same cycle comes after
    task automatic issue_store(input logic [SCPAD_ADDR_WIDTH-1:0] row,
                               input logic [DRAM_ADDR_WIDTH-1:0] addr,
                               input logic [DRAM_ID_WIDTH-1:0] id,
                               input num_bytes_t nb);
        exp_req_t req;
        req.addr      = addr;
        req.id        = id;
        req.num_bytes = nb;
        req.data      = masked_row(model_rows[row], nb);
        exp_q.push_back(req);
        sched_write     = 1'b1;
        sched_sram_addr = row;
        sched_dram_addr = addr;
        sched_id        = id;
        sched_num_bytes = nb;
    endtask

    task automatic issue_random_store(input logic [SCPAD_ADDR_WIDTH-1:0] row);
        issue_store(row, $random(seed), DRAM_ID_WIDTH'(rand_below(32)),
                    num_bytes_t'(rand_below(ROW_BYTES + 1)));
    endtask

    // accept everything until the model queue is empty
    task automatic drain();
        int guard;
        guard = 0;
        accept_pct = 100;
        while (exp_q.size() != 0 && guard < 4 * QUEUE_DEPTH + 20) begin
            tick();
            guard++;
        end
        checks++;
        assert (exp_q.size() == 0) else begin
            $display("requests still missing after drain wait, %0d left", exp_q.size());
            errors++;
        end
        tick();
        check_flag(!sampled_valid, "dram_wr_valid still high after drain");
    endtask

    task automatic end_test(input string name);
        $display("test %s finished, %0d errors", name, errors - errors_before_test);
        errors_before_test = errors;
    endtask

    task automatic test_reset_state();
        check_flag(!dram_wr_valid, "dram_wr_valid high after reset");
        check_flag(!sched_busy, "sched_busy high after reset");
        accept_pct = 100;
        tick();
        issue_random_store(SCPAD_ADDR_WIDTH'(rand_below(SCPAD_ROWS)));
        drain();
        compare_field(64'(last_data), 64'(0), "unwritten row data");
        end_test("reset_state");
    endtask

    task automatic test_single_stores();
        logic [SCPAD_ADDR_WIDTH-1:0] row;
        accept_pct = 100;
        for (int i = 0; i < 20; i++) begin
            row = SCPAD_ADDR_WIDTH'(rand_below(SCPAD_ROWS));
            tick();
            host_write(row, rand_row());
            tick();
            issue_random_store(row);
            // strobe cycle, then one cycle of sram read and push
            tick();
            check_flag(!sampled_valid, "dram_wr_valid high in strobe cycle");
            tick();
            check_flag(!sampled_valid, "dram_wr_valid high one cycle after strobe");
            tick();
            check_flag(sampled_valid, "dram_wr_valid low two cycles after strobe");
            drain();
        end
        end_test("single_stores");
    endtask

    task automatic test_back_to_back();
        int strobes;
        strobes = 0;
        accept_pct = 50;
        while (strobes < 16) begin
            tick();
            if (!sched_busy) begin
                // id follows strobe order
                issue_store(SCPAD_ADDR_WIDTH'(rand_below(SCPAD_ROWS)), $random(seed),
                            DRAM_ID_WIDTH'(strobes),
                            num_bytes_t'(rand_below(ROW_BYTES + 1)));
                strobes++;
            end
        end
        drain();
        end_test("back_to_back");
    endtask

    task automatic test_back_pressure();
        int strobes;
        int guard;
        logic busy_seen;
        strobes   = 0;
        guard     = 0;
        busy_seen = 1'b0;
        accept_pct = 0;
        while (!busy_seen && guard < 3 * QUEUE_DEPTH) begin
            tick();
            if (sched_busy) begin
                busy_seen = 1'b1;
            end else begin
                issue_random_store(SCPAD_ADDR_WIDTH'(rand_below(SCPAD_ROWS)));
                strobes++;
            end
            guard++;
        end
        check_flag(busy_seen, "sched_busy never rose with acceptance held low");
        check_flag(strobes <= QUEUE_DEPTH, "more stores taken than queue slots");
        // hold a few cycles, nothing may leave or get lost
        // oldest request stays on the dram fields unchanged
        repeat (4) begin
            tick();
            check_flag(sched_busy, "sched_busy fell while queue held full");
            if (exp_q.size() != 0) begin
                compare_field(64'(dram_wr_addr), 64'(exp_q[0].addr), "held dram_wr_addr");
                compare_field(64'(dram_wr_id), 64'(exp_q[0].id), "held dram_wr_id");
                compare_field(64'(dram_wr_num_bytes), 64'(exp_q[0].num_bytes),
                              "held dram_wr_num_bytes");
                compare_field(64'(dram_wr_data), 64'(exp_q[0].data), "held dram_wr_data");
            end
        end
        check_flag(sampled_valid, "dram_wr_valid low with requests queued");
        drain();
        check_flag(!sched_busy, "sched_busy still high after drain");
        end_test("back_pressure");
    endtask

    task automatic test_same_cycle_write();
        logic [SCPAD_ADDR_WIDTH-1:0] row;
        scpad_data_t old_row;
        scpad_data_t new_row;
        row     = SCPAD_ADDR_WIDTH'(rand_below(SCPAD_ROWS));
        old_row = rand_row();
        new_row = rand_row();
        accept_pct = 100;
        tick();
        host_write(row, old_row);
        tick();
        // full row store and host write in one cycle
        issue_store(row, $random(seed), DRAM_ID_WIDTH'(rand_below(32)), '0);
        host_write(row, new_row);
        drain();
        compare_field(64'(last_data), 64'(old_row), "same cycle store data");
        tick();
        issue_store(row, $random(seed), DRAM_ID_WIDTH'(rand_below(32)), '0);
        drain();
        compare_field(64'(last_data), 64'(new_row), "later store data");
        end_test("same_cycle_write");
    endtask

    task automatic test_random_mix();
        accept_pct = 50;
        for (int c = 0; c < MIX_CYCLES; c++) begin
            tick();
            if (!sched_busy && rand_below(100) < 40) begin
                issue_random_store(SCPAD_ADDR_WIDTH'(rand_below(SCPAD_ROWS)));
            end
            if (rand_below(100) < 50) begin
                host_write(SCPAD_ADDR_WIDTH'(rand_below(SCPAD_ROWS)), rand_row());
            end
        end
        drain();
        check_flag(exp_q.size() == 0, "model queue not empty at end of mix");
        end_test("random_mix");
    endtask

    // run limit
    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run did not end within %0d cycles", CYCLE_LIMIT);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        clk               = 1'b0;
        n_rst             = 1'b0;
        host_we           = 1'b0;
        host_addr         = '0;
        host_wdata        = '0;
        sched_write       = 1'b0;
        sched_sram_addr   = '0;
        sched_dram_addr   = '0;
        sched_id          = '0;
        sched_num_bytes   = '0;
        dram_req_accepted = 1'b0;
        errors             = 0;
        checks             = 0;
        errors_before_test = 0;
        accept_pct         = 0;
        sampled_valid      = 1'b0;
        last_data          = '0;
        // sram comes out of reset all zero
        for (int r = 0; r < SCPAD_ROWS; r++) begin
            model_rows[r] = '0;
        end

        repeat (8) @(posedge clk);
        #2;
        n_rst = 1'b1;

        test_reset_state();
        test_single_stores();
        test_back_to_back();
        test_back_pressure();
        test_same_cycle_write();
        test_random_mix();

        $display("tests 6, checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* design/scpad_backend_top.sv */
`timescale 1ns/1ps

module scpad_backend_top #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                                         clk,
    input  logic                                         n_rst,
    // host write port
    input  logic                                         host_we,
    input  logic [scpad_types_pkg::SCPAD_ADDR_WIDTH-1:0] host_addr,
    input  scpad_types_pkg::scpad_data_t                 host_wdata,
    // scheduler store command
    input  logic                                         sched_write,
    input  logic [scpad_types_pkg::SCPAD_ADDR_WIDTH-1:0] sched_sram_addr,
    input  logic [dram_bus_pkg::DRAM_ADDR_WIDTH-1:0]     sched_dram_addr,
    input  logic [dram_bus_pkg::DRAM_ID_WIDTH-1:0]       sched_id,
    input  dram_bus_pkg::num_bytes_t                     sched_num_bytes,
    output logic                                         sched_busy,
    // dram write request
    output logic                                         dram_wr_valid,
    output logic [dram_bus_pkg::DRAM_ADDR_WIDTH-1:0]     dram_wr_addr,
    output logic [dram_bus_pkg::DRAM_ID_WIDTH-1:0]       dram_wr_id,
    output dram_bus_pkg::num_bytes_t                     dram_wr_num_bytes,
    output scpad_types_pkg::scpad_data_t                 dram_wr_data,
    input  logic                                         dram_req_accepted
);
    import scpad_types_pkg::*;
    import dram_bus_pkg::*;

    // engine to sram
    logic                        rd_en;
    logic [SCPAD_ADDR_WIDTH-1:0] rd_addr;
    scpad_data_t                 rd_data;

    // engine to queue
    logic                        push;
    logic [DRAM_ADDR_WIDTH-1:0]  push_addr;
    logic [DRAM_ID_WIDTH-1:0]    push_id;
    num_bytes_t                  push_num_bytes;
    scpad_data_t                 push_data;

    // queue to engine
    logic                        queue_full;
    logic                        queue_almost_full;

    // scratchpad rows
    scpad_sram_bank sram0 (
        .clk        (clk),
        .n_rst      (n_rst),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data)
    );

    // store path control and byte masking
    scpad_store_engine #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) engine0 (
        .clk               (clk),
        .n_rst             (n_rst),
        .sched_write       (sched_write),
        .sched_sram_addr   (sched_sram_addr),
        .sched_dram_addr   (sched_dram_addr),
        .sched_id          (sched_id),
        .sched_num_bytes   (sched_num_bytes),
        .sched_busy        (sched_busy),
        .rd_en             (rd_en),
        .rd_addr           (rd_addr),
        .rd_data           (rd_data),
        .queue_full        (queue_full),
        .queue_almost_full (queue_almost_full),
        .push              (push),
        .push_addr         (push_addr),
        .push_id           (push_id),
        .push_num_bytes    (push_num_bytes),
        .push_data         (push_data)
    );

    // in-order write requests toward the dram controller
    dram_write_req_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) queue0 (
        .clk               (clk),
        .n_rst             (n_rst),
        .push              (push),
        .push_addr         (push_addr),
        .push_id           (push_id),
        .push_num_bytes    (push_num_bytes),
        .push_data         (push_data),
        .full              (queue_full),
        .almost_full       (queue_almost_full),
        .dram_wr_valid     (dram_wr_valid),
        .dram_wr_addr      (dram_wr_addr),
        .dram_wr_id        (dram_wr_id),
        .dram_wr_num_bytes (dram_wr_num_bytes),
        .dram_wr_data      (dram_wr_data),
        .dram_req_accepted (dram_req_accepted)
    );

endmodule

/* design/dram_write_req_queue.sv */
`timescale 1ns/1ps

module dram_write_req_queue #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                                     clk,
    input  logic                                     n_rst,
    // push side from the store engine
    input  logic                                     push,
    input  logic [dram_bus_pkg::DRAM_ADDR_WIDTH-1:0] push_addr,
    input  logic [dram_bus_pkg::DRAM_ID_WIDTH-1:0]   push_id,
    input  dram_bus_pkg::num_bytes_t                 push_num_bytes,
    input  scpad_types_pkg::scpad_data_t             push_data,
    output logic                                     full,
    output logic                                     almost_full,
    // head request to the dram controller
    output logic                                     dram_wr_valid,
    output logic [dram_bus_pkg::DRAM_ADDR_WIDTH-1:0] dram_wr_addr,
    output logic [dram_bus_pkg::DRAM_ID_WIDTH-1:0]   dram_wr_id,
    output dram_bus_pkg::num_bytes_t                 dram_wr_num_bytes,
    output scpad_types_pkg::scpad_data_t             dram_wr_data,
    input  logic                                     dram_req_accepted
);
    import scpad_types_pkg::*;
    import dram_bus_pkg::*;

    // slot index width
    // at least one bit so a depth of 1 still elaborates
    localparam int IDX_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    // pointer width with the wrap bit
    localparam int PTR_W = IDX_W + 1;
    // storage slots, equal to the depth for power of two depths
    localparam int SLOTS = 1 << IDX_W;

    // request storage
    logic [DRAM_ADDR_WIDTH-1:0] addr_mem [SLOTS];
    logic [DRAM_ID_WIDTH-1:0]   id_mem   [SLOTS];
    num_bytes_t                 nb_mem   [SLOTS];
    scpad_data_t                data_mem [SLOTS];

    // head is the oldest entry, tail the next free slot
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [PTR_W-1:0] count;
    logic [IDX_W-1:0] head_idx;
    logic [IDX_W-1:0] tail_idx;

    logic empty;
    logic do_push;
    logic do_pop;

    assign head_idx = head[IDX_W-1:0];
    assign tail_idx = tail[IDX_W-1:0];

    // occupancy
    // wrap bit keeps a full queue apart from an empty one
    assign count       = tail - head;
    assign empty       = (head == tail);
    assign full        = (count == PTR_W'(QUEUE_DEPTH));
    assign almost_full = (count == PTR_W'(QUEUE_DEPTH - 1));

    // a push into a full queue is dropped
    // it would otherwise land on the head entry
    assign do_push = push && !full;
    // head leaves on every accepted cycle
    assign do_pop  = dram_wr_valid && dram_req_accepted;

    // pointers
    // push and pop in one cycle move both
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            head <= '0;
            tail <= '0;
        end else begin
            if (do_push) begin
                tail <= tail + PTR_W'(1);
            end
            if (do_pop) begin
                head <= head + PTR_W'(1);
            end
        end
    end

    // entry write at the tail
    always_ff @(posedge clk) begin
        if (do_push) begin
            addr_mem[tail_idx] <= push_addr;
            id_mem[tail_idx]   <= push_id;
            nb_mem[tail_idx]   <= push_num_bytes;
            data_mem[tail_idx] <= push_data;
        end
    end

    // head presentation
    // fields come straight from the head slot
    // they hold until the head moves
    assign dram_wr_valid     = !empty;
    assign dram_wr_addr      = addr_mem[head_idx];
    assign dram_wr_id        = id_mem[head_idx];
    assign dram_wr_num_bytes = nb_mem[head_idx];
    assign dram_wr_data      = data_mem[head_idx];

    // engine busy logic must keep pushes away from a full queue
    push_while_full: assert property (
        @(posedge clk) disable iff (!n_rst)
        push |-> !full
    ) else $error("push into full write queue, depth %0d", QUEUE_DEPTH);

    // controller accepts only a presented request
    accept_without_valid: assert property (
        @(posedge clk) disable iff (!n_rst)
        dram_req_accepted |-> dram_wr_valid
    ) else $error("dram acceptance with no valid request");

endmodule

/* design/scpad_store_engine.sv */
`timescale 1ns/1ps

module scpad_store_engine #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                                         clk,
    input  logic                                         n_rst,
    // store command from the scheduler
    input  logic                                         sched_write,
    input  logic [scpad_types_pkg::SCPAD_ADDR_WIDTH-1:0] sched_sram_addr,
    input  logic [dram_bus_pkg::DRAM_ADDR_WIDTH-1:0]     sched_dram_addr,
    input  logic [dram_bus_pkg::DRAM_ID_WIDTH-1:0]       sched_id,
    input  dram_bus_pkg::num_bytes_t                     sched_num_bytes,
    output logic                                         sched_busy,
    // sram read port
    output logic                                         rd_en,
    output logic [scpad_types_pkg::SCPAD_ADDR_WIDTH-1:0] rd_addr,
    input  scpad_types_pkg::scpad_data_t                 rd_data,
    // queue status
    input  logic                                         queue_full,
    input  logic                                         queue_almost_full,
    // queue push side
    output logic                                         push,
    output logic [dram_bus_pkg::DRAM_ADDR_WIDTH-1:0]     push_addr,
    output logic [dram_bus_pkg::DRAM_ID_WIDTH-1:0]       push_id,
    output dram_bus_pkg::num_bytes_t                     push_num_bytes,
    output scpad_types_pkg::scpad_data_t                 push_data
);
    import scpad_types_pkg::*;
    import dram_bus_pkg::*;

    // read issued last cycle
    // its row is on rd_data now
    logic in_flight;

    // command fields held across the sram read
    logic [DRAM_ADDR_WIDTH-1:0] pend_addr;
    logic [DRAM_ID_WIDTH-1:0]   pend_id;
    num_bytes_t                 pend_num_bytes;

    // byte count with zero mapped to a full row
    num_bytes_t eff_bytes;

    // strobe goes straight to the sram
    // the row is registered at the edge that ends the strobe cycle
    assign rd_en   = sched_write;
    assign rd_addr = sched_sram_addr;

    // in-flight flag
    // one store per strobe, back to back strobes keep it high
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            in_flight <= 1'b0;
        end else begin
            in_flight <= sched_write;
        end
    end

    // capture the dram side of the command
    always_ff @(posedge clk) begin
        if (sched_write) begin
            pend_addr      <= sched_dram_addr;
            pend_id        <= sched_id;
            pend_num_bytes <= sched_num_bytes;
        end
    end

    // zero count selects the full row
    assign eff_bytes = (pend_num_bytes == '0) ? num_bytes_t'(ROW_BYTES) : pend_num_bytes;

    // byte masking
    // lanes below the count pass through
    // lanes at or above the count are cleared
    always_comb begin
        for (int b = 0; b < ROW_BYTES; b++) begin
            if (num_bytes_t'(b) < eff_bytes) begin
                push_data[b] = rd_data[b];
            end else begin
                push_data[b] = '0;
            end
        end
    end

    // push in the cycle after the strobe
    // the count goes out as the scheduler gave it
    assign push           = in_flight;
    assign push_addr      = pend_addr;
    assign push_id        = pend_id;
    assign push_num_bytes = pend_num_bytes;

    // back-pressure to the scheduler
    // full queue blocks outright
    // one slot left is taken by the read in flight
    assign sched_busy = queue_full || (queue_almost_full && in_flight);

    // scheduler must respect busy
    // otherwise the queue would take a push while full
    sched_write_while_busy: assert property (
        @(posedge clk) disable iff (!n_rst)
        sched_write |-> !sched_busy
    ) else $error("store strobe while busy, queue depth %0d", QUEUE_DEPTH);

endmodule

/* design/scpad_sram_bank.sv */
`timescale 1ns/1ps

module scpad_sram_bank (
    input  logic                                         clk,
    input  logic                                         n_rst,
    // host write port
    input  logic                                         host_we,
    input  logic [scpad_types_pkg::SCPAD_ADDR_WIDTH-1:0] host_addr,
    input  scpad_types_pkg::scpad_data_t                 host_wdata,
    // read port from the store engine
    input  logic                                         rd_en,
    input  logic [scpad_types_pkg::SCPAD_ADDR_WIDTH-1:0] rd_addr,
    output scpad_types_pkg::scpad_data_t                 rd_data
);
    import scpad_types_pkg::*;

    // row storage
    // one entry per row address
    scpad_data_t rows [SCPAD_ROWS];

    // host writes
    // whole array goes to zero on reset
    // so a store of an unwritten row returns zeros
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            for (int r = 0; r < SCPAD_ROWS; r++) begin
                rows[r] <= '0;
            end
        end else if (host_we) begin
            // write lands at the edge
            rows[host_addr] <= host_wdata;
        end
    end

    // registered read
    // row shows up on rd_data the cycle after rd_en
    // both blocks update at the same edge
    // a same row host write in the read cycle is not seen here
    // the old row comes back and the new one is visible next read
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= rows[rd_addr];
        end
        // no read this cycle
        // rd_data keeps the last row read
    end

endmodule

/* design/dram_bus_pkg.sv */
package dram_bus_pkg;

    // dram side of the backend
    // request fields seen by the dram controller

    // byte address into dram
    parameter int DRAM_ADDR_WIDTH = 32;

    // request id width
    // 5 bits gives 32 ids
    parameter int DRAM_ID_WIDTH = 5;

    // width of the byte count field
    parameter int NUM_BYTES_WIDTH = 4;

    // byte count of one write request
    // legal counts are 1 to 8
    // a count of 0 stands for a full 8 byte row
    typedef logic [NUM_BYTES_WIDTH-1:0] num_bytes_t;

endpackage

/* design/scpad_types_pkg.sv */
package scpad_types_pkg;

    // scratchpad side of the backend
    // row geometry and row address

    // bytes held in one scratchpad row
    parameter int ROW_BYTES = 8;

    // bits per byte lane
    parameter int BYTE_WIDTH = 8;

    // row address width
    // 6 bits gives 64 rows
    parameter int SCPAD_ADDR_WIDTH = 6;

    // one row per address value
    parameter int SCPAD_ROWS = 1 << SCPAD_ADDR_WIDTH;

    // one row as packed byte lanes
    // lane 0 sits in the low bits, lane ROW_BYTES-1 in the high bits
    // 8 lanes of 8 bits, 64 bits in all
    typedef logic [ROW_BYTES-1:0][BYTE_WIDTH-1:0] scpad_data_t;

endpackage
